// File: project.f
src/rr_pkg.sv
src/rr_req_if.sv
src/rr_chan_tap.sv
src/rr_log_arbiter.sv
src/rr_trace_buffer.sv
src/rr_replayer.sv
src/rr_csrs.sv
src/rr_top.sv
tb/rr_checker.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the record/replay testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_top -f project.f

# the log decides the result, not the exit status of the run
./obj_dir/Vtb_top 2>&1 | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
  exit 0
fi
exit 1

// File: src/rr_chan_tap.sv
`timescale 1ns/1ps
`default_nettype none

module rr_chan_tap (
  input  wire                        clk,
  input  wire                        rstn,
  input  rr_pkg::rr_mode_e           i_mode,
  // host side
  input  wire                        i_host_valid,
  input  wire [rr_pkg::ADDR_W-1:0]   i_host_addr,
  input  wire [rr_pkg::DATA_W-1:0]   i_host_data,
  output logic                       o_host_ready,
  // core side
  output logic                       o_core_valid,
  output logic [rr_pkg::ADDR_W-1:0]  o_core_addr,
  output logic [rr_pkg::DATA_W-1:0]  o_core_data,
  input  wire                        i_core_ready,
  // log stream to the arbiter and replay stream from the replayer
  rr_req_if.src                      log,
  rr_req_if.snk                      rply
);
  import rr_pkg::*;

  ////////////////////////////////////////
  // source select and record tap
  ////////////////////////////////////////
  always_comb begin
    // log always carries the host request and only valid depends on the mode
    log.addr = i_host_addr;
    log.data = i_host_data;
    case (i_mode)
      RR_MODE_RECORD: begin
        // ask for a log slot only when the core can take it this cycle
        log.valid    = i_host_valid & i_core_ready;
        // core sees the request only while the log slot is granted
        o_core_valid = i_host_valid & log.ready;
        o_core_addr  = i_host_addr;
        o_core_data  = i_host_data;
        o_host_ready = i_core_ready & log.ready;
        rply.ready   = 1'b0;
      end
      RR_MODE_REPLAY: begin
        // host is shut off and the replayer drives the core
        log.valid    = 1'b0;
        o_core_valid = rply.valid;
        o_core_addr  = rply.addr;
        o_core_data  = rply.data;
        o_host_ready = 1'b0;
        rply.ready   = i_core_ready;
      end
      default: begin
        // pass mode wires the host straight to the core
        log.valid    = 1'b0;
        o_core_valid = i_host_valid;
        o_core_addr  = i_host_addr;
        o_core_data  = i_host_data;
        o_host_ready = i_core_ready;
        rply.ready   = 1'b0;
      end
    endcase
  end

  // in record mode a request reaches the core only with a granted log slot
  a_rec_core_needs_grant : assert property (
    @(posedge clk) disable iff (!rstn)
    (i_mode == RR_MODE_RECORD && o_core_valid) |-> log.valid && log.ready
  );

endmodule

`default_nettype wire

// File: src/rr_csrs.sv
`timescale 1ns/1ps
`default_nettype none

module rr_csrs #(
  parameter int TRACE_DEPTH = rr_pkg::TRACE_DEPTH_DEF
) (
  input  wire                              clk,
  input  wire                              rstn,
  // register port
  input  wire                              i_cfg_we,
  input  wire                              i_cfg_re,
  input  wire [rr_pkg::CFG_ADDR_W-1:0]     i_cfg_addr,
  input  wire [rr_pkg::CFG_DATA_W-1:0]     i_cfg_wdata,
  output logic [rr_pkg::CFG_DATA_W-1:0]    o_cfg_rdata,
  // to and from the datapath
  output rr_pkg::rr_mode_e                 o_mode,
  input  wire [$clog2(TRACE_DEPTH):0]      i_count,
  input  wire                              i_full,
  input  wire                              i_replay_done
);
  import rr_pkg::*;

  rr_mode_e              mode_q;
  logic                  replay_done_q;
  logic                  mode_wr;
  logic [CFG_DATA_W-1:0] status;

  assign mode_wr = i_cfg_we && (i_cfg_addr == CSR_MODE);

  ////////////////////////////////////////
  // mode and one-off status
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      mode_q        <= RR_MODE_PASS;
      replay_done_q <= 1'b0;
    end else begin
      // undefined mode values are dropped
      if (mode_wr && (i_cfg_wdata <= CFG_DATA_W'(RR_MODE_REPLAY))) begin
        mode_q <= rr_mode_e'(i_cfg_wdata[$bits(rr_mode_e)-1:0]);
      end
      // any mode write clears done, a new done pulse wins
      replay_done_q <= (replay_done_q & ~mode_wr) | i_replay_done;
    end
  end

  assign o_mode = mode_q;

  // sticky bits from the register, real-time bits straight through
  always_comb begin
    status                   = '0;
    status[STAT_REPLAY_DONE] = replay_done_q;
    status[STAT_FULL]        = i_full;
  end

  ////////////////////////////////////////
  // registered read
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_cfg_rdata <= '0;
    end else if (i_cfg_re) begin
      case (i_cfg_addr)
        CSR_MODE:   o_cfg_rdata <= CFG_DATA_W'(mode_q);
        CSR_COUNT:  o_cfg_rdata <= CFG_DATA_W'(i_count);
        CSR_STATUS: o_cfg_rdata <= status;
        default:    o_cfg_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/rr_log_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_log_arbiter (
  input  wire                   clk,
  input  wire                   rstn,
  rr_req_if.snk                 log0,
  rr_req_if.snk                 log1,
  // trace buffer push port
  input  wire                   i_full,
  output logic                  o_push,
  output rr_pkg::trace_entry_t  o_entry
);
  import rr_pkg::*;

  // round-robin pointer, 1 when channel 1 has priority
  logic prio1_q;
  logic grant0;
  logic grant1;

  ////////////////////////////////////////
  // grant, one channel per cycle
  ////////////////////////////////////////
  // a full buffer blocks both channels
  assign grant0 = log0.valid & ~i_full & (~prio1_q | ~log1.valid);
  assign grant1 = log1.valid & ~i_full & (prio1_q | ~log0.valid);

  assign log0.ready = grant0;
  assign log1.ready = grant1;
  assign o_push     = grant0 | grant1;

  // stamp the granted channel into the entry
  always_comb begin
    o_entry.chan = CHAN_W'(grant1);
    o_entry.addr = grant1 ? log1.addr : log0.addr;
    o_entry.data = grant1 ? log1.data : log0.data;
  end

  // pointer moves past the channel just served
  always_ff @(posedge clk) begin
    if (!rstn) begin
      prio1_q <= 1'b0;
    end else if (grant0) begin
      prio1_q <= 1'b1;
    end else if (grant1) begin
      prio1_q <= 1'b0;
    end
  end

  a_one_grant : assert property (
    @(posedge clk) disable iff (!rstn)
    !(log0.ready && log1.ready)
  );

endmodule

`default_nettype wire

// File: src/rr_pkg.sv
`default_nettype none

package rr_pkg;

  ////////////////////////////////////////
  // request channel widths
  ////////////////////////////////////////
  // address and data of one write request
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  // channel id, 0 is sda and 1 is ocl
  localparam int CHAN_W = 1;

  // default trace depth, must be a power of two and at least 4
  localparam int TRACE_DEPTH_DEF = 16;

  // one logged request as it sits in the trace buffer
  typedef struct packed {
    logic [CHAN_W-1:0] chan;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } trace_entry_t;

  ////////////////////////////////////////
  // register port
  ////////////////////////////////////////
  localparam int CFG_ADDR_W = 4;
  localparam int CFG_DATA_W = 32;

  // operating mode, value 3 is undefined
  typedef enum logic [1:0] {
    RR_MODE_PASS   = 2'd0,
    RR_MODE_RECORD = 2'd1,
    RR_MODE_REPLAY = 2'd2
  } rr_mode_e;

  // register map
  typedef enum logic [CFG_ADDR_W-1:0] {
    CSR_MODE   = 4'd0,
    CSR_COUNT  = 4'd1,
    CSR_STATUS = 4'd2
  } rr_csr_addr_e;

  // status word bits
  // one-off bit, sticky until the mode register is written
  localparam int STAT_REPLAY_DONE = 0;
  // real-time bit, follows the buffer
  localparam int STAT_FULL = 1;

endpackage

`default_nettype wire

// File: src/rr_replayer.sv
`timescale 1ns/1ps
`default_nettype none

module rr_replayer (
  input  wire                   clk,
  input  wire                   rstn,
  input  rr_pkg::rr_mode_e      i_mode,
  // buffer head, first-word fall-through
  input  wire                   i_head_valid,
  input  rr_pkg::trace_entry_t  i_head,
  output logic                  o_pop,
  // per-channel dispatch
  rr_req_if.src                 rply0,
  rr_req_if.src                 rply1,
  output logic                  o_replay_done
);
  import rr_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } rply_state_e;

  rply_state_e state_q;
  rply_state_e state_d;
  logic        in_replay;
  logic        issue;

  assign in_replay = (i_mode == RR_MODE_REPLAY);

  ////////////////////////////////////////
  // sequencer FSM
  ////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (in_replay) begin
          state_d = ST_RUN;
        end
      end
      ST_RUN: begin
        if (!in_replay) begin
          state_d = ST_IDLE;
        end else if (!i_head_valid) begin
          state_d = ST_DONE;
        end
      end
      ST_DONE: begin
        // wait here until the host picks another mode
        if (!in_replay) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // single pulse on the way from run to done
  assign o_replay_done = (state_q == ST_RUN) && in_replay && !i_head_valid;

  ////////////////////////////////////////
  // dispatch
  ////////////////////////////////////////
  // head entry is in flight until its channel takes it
  assign issue = (state_q == ST_RUN) && in_replay && i_head_valid;

  assign rply0.valid = issue && (i_head.chan == CHAN_W'(0));
  assign rply1.valid = issue && (i_head.chan == CHAN_W'(1));
  assign rply0.addr  = i_head.addr;
  assign rply0.data  = i_head.data;
  assign rply1.addr  = i_head.addr;
  assign rply1.data  = i_head.data;

  // pop on the transfer edge
  assign o_pop = (rply0.valid && rply0.ready) || (rply1.valid && rply1.ready);

  // buffer keeps the head still while it waits for the core
  a_head_held : assert property (
    @(posedge clk) disable iff (!rstn)
    (issue && !o_pop) |=> $stable(i_head)
  );

endmodule

`default_nettype wire

// File: src/rr_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// write request channel with valid/ready handshake
interface rr_req_if;
  import rr_pkg::*;

  logic              valid;
  logic              ready;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;

  // side that issues the request
  modport src (
    output valid, addr, data,
    input  ready
  );

  // side that takes the request
  modport snk (
    input  valid, addr, data,
    output ready
  );

endinterface

`default_nettype wire

// File: src/rr_top.sv
`timescale 1ns/1ps
`default_nettype none

module rr_top #(
  parameter int TRACE_DEPTH = rr_pkg::TRACE_DEPTH_DEF
) (
  input  wire                             clk,
  input  wire                             rstn,
  // channel 0 (sda) host and core sides
  input  wire                             i_host_c0_valid,
  input  wire [rr_pkg::ADDR_W-1:0]        i_host_c0_addr,
  input  wire [rr_pkg::DATA_W-1:0]        i_host_c0_data,
  output logic                            o_host_c0_ready,
  output logic                            o_core_c0_valid,
  output logic [rr_pkg::ADDR_W-1:0]       o_core_c0_addr,
  output logic [rr_pkg::DATA_W-1:0]       o_core_c0_data,
  input  wire                             i_core_c0_ready,
  // channel 1 (ocl) host and core sides
  input  wire                             i_host_c1_valid,
  input  wire [rr_pkg::ADDR_W-1:0]        i_host_c1_addr,
  input  wire [rr_pkg::DATA_W-1:0]        i_host_c1_data,
  output logic                            o_host_c1_ready,
  output logic                            o_core_c1_valid,
  output logic [rr_pkg::ADDR_W-1:0]       o_core_c1_addr,
  output logic [rr_pkg::DATA_W-1:0]       o_core_c1_data,
  input  wire                             i_core_c1_ready,
  // register port
  input  wire                             i_cfg_we,
  input  wire                             i_cfg_re,
  input  wire [rr_pkg::CFG_ADDR_W-1:0]    i_cfg_addr,
  input  wire [rr_pkg::CFG_DATA_W-1:0]    i_cfg_wdata,
  output logic [rr_pkg::CFG_DATA_W-1:0]   o_cfg_rdata
);
  import rr_pkg::*;

  localparam int CNT_W = $clog2(TRACE_DEPTH) + 1;

  rr_mode_e     mode;
  logic         push;
  trace_entry_t push_entry;
  logic         full;
  logic         head_valid;
  trace_entry_t head;
  logic         pop;
  logic [CNT_W-1:0] count;
  logic         replay_done;

  // log streams into the arbiter, replay streams out of the replayer
  rr_req_if log_c0 ();
  rr_req_if log_c1 ();
  rr_req_if rply_c0 ();
  rr_req_if rply_c1 ();

  ////////////////////////////////////////
  // channel taps
  ////////////////////////////////////////
  rr_chan_tap tap_c0 (
    .clk          (clk),
    .rstn         (rstn),
    .i_mode       (mode),
    .i_host_valid (i_host_c0_valid),
    .i_host_addr  (i_host_c0_addr),
    .i_host_data  (i_host_c0_data),
    .o_host_ready (o_host_c0_ready),
    .o_core_valid (o_core_c0_valid),
    .o_core_addr  (o_core_c0_addr),
    .o_core_data  (o_core_c0_data),
    .i_core_ready (i_core_c0_ready),
    .log          (log_c0),
    .rply         (rply_c0)
  );

  rr_chan_tap tap_c1 (
    .clk          (clk),
    .rstn         (rstn),
    .i_mode       (mode),
    .i_host_valid (i_host_c1_valid),
    .i_host_addr  (i_host_c1_addr),
    .i_host_data  (i_host_c1_data),
    .o_host_ready (o_host_c1_ready),
    .o_core_valid (o_core_c1_valid),
    .o_core_addr  (o_core_c1_addr),
    .o_core_data  (o_core_c1_data),
    .i_core_ready (i_core_c1_ready),
    .log          (log_c1),
    .rply         (rply_c1)
  );

  ////////////////////////////////////////
  // record path, merge then store
  ////////////////////////////////////////
  rr_log_arbiter arbiter (
    .clk     (clk),
    .rstn    (rstn),
    .log0    (log_c0),
    .log1    (log_c1),
    .i_full  (full),
    .o_push  (push),
    .o_entry (push_entry)
  );

  rr_trace_buffer #(
    .TRACE_DEPTH (TRACE_DEPTH)
  ) trace_buf (
    .clk          (clk),
    .rstn         (rstn),
    .i_push       (push),
    .i_entry      (push_entry),
    .o_full       (full),
    .i_pop        (pop),
    .o_head_valid (head_valid),
    .o_head       (head),
    .o_count      (count)
  );

  // replay path, drains the buffer in trace order
  rr_replayer replayer (
    .clk           (clk),
    .rstn          (rstn),
    .i_mode        (mode),
    .i_head_valid  (head_valid),
    .i_head        (head),
    .o_pop         (pop),
    .rply0         (rply_c0),
    .rply1         (rply_c1),
    .o_replay_done (replay_done)
  );

  rr_csrs #(
    .TRACE_DEPTH (TRACE_DEPTH)
  ) csrs (
    .clk           (clk),
    .rstn          (rstn),
    .i_cfg_we      (i_cfg_we),
    .i_cfg_re      (i_cfg_re),
    .i_cfg_addr    (i_cfg_addr),
    .i_cfg_wdata   (i_cfg_wdata),
    .o_cfg_rdata   (o_cfg_rdata),
    .o_mode        (mode),
    .i_count       (count),
    .i_full        (full),
    .i_replay_done (replay_done)
  );

endmodule

`default_nettype wire

// File: src/rr_trace_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module rr_trace_buffer #(
  parameter int TRACE_DEPTH = rr_pkg::TRACE_DEPTH_DEF
) (
  input  wire                            clk,
  input  wire                            rstn,
  // write side from the arbiter
  input  wire                            i_push,
  input  rr_pkg::trace_entry_t           i_entry,
  output logic                           o_full,
  // first-word fall-through read side
  input  wire                            i_pop,
  output logic                           o_head_valid,
  output rr_pkg::trace_entry_t           o_head,
  output logic [$clog2(TRACE_DEPTH):0]   o_count
);
  import rr_pkg::*;

  localparam int PTR_W = $clog2(TRACE_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  trace_entry_t     mem [TRACE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_entry;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // occupancy, unchanged on push and pop together
      if (i_push && !i_pop) begin
        count <= count + 1'b1;
      end else if (i_pop && !i_push) begin
        count <= count - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // status and head
  ////////////////////////////////////////
  assign o_full       = (count == CNT_W'(TRACE_DEPTH));
  assign o_head_valid = (count != '0);
  assign o_head       = mem[rd_ptr];
  assign o_count      = count;

  // arbiter must respect full, replayer must respect head valid
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rstn)
    i_push |-> !o_full
  );
  a_no_underflow : assert property (
    @(posedge clk) disable iff (!rstn)
    i_pop |-> o_head_valid
  );

endmodule

`default_nettype wire

// File: tb/rr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rr_checker #(
  parameter int TRACE_DEPTH = rr_pkg::TRACE_DEPTH_DEF
) (
  input  wire                           clk,
  input  wire                           rstn,
  // channel 0 as seen on the DUT ports
  input  wire                           i_host_c0_valid,
  input  wire                           i_host_c0_ready,
  input  wire [rr_pkg::ADDR_W-1:0]      i_host_c0_addr,
  input  wire [rr_pkg::DATA_W-1:0]      i_host_c0_data,
  input  wire                           i_core_c0_valid,
  input  wire                           i_core_c0_ready,
  input  wire [rr_pkg::ADDR_W-1:0]      i_core_c0_addr,
  input  wire [rr_pkg::DATA_W-1:0]      i_core_c0_data,
  // channel 1
  input  wire                           i_host_c1_valid,
  input  wire                           i_host_c1_ready,
  input  wire [rr_pkg::ADDR_W-1:0]      i_host_c1_addr,
  input  wire [rr_pkg::DATA_W-1:0]      i_host_c1_data,
  input  wire                           i_core_c1_valid,
  input  wire                           i_core_c1_ready,
  input  wire [rr_pkg::ADDR_W-1:0]      i_core_c1_addr,
  input  wire [rr_pkg::DATA_W-1:0]      i_core_c1_data,
  // register writes, to follow the mode
  input  wire                           i_cfg_we,
  input  wire [rr_pkg::CFG_ADDR_W-1:0]  i_cfg_addr,
  input  wire [rr_pkg::CFG_DATA_W-1:0]  i_cfg_wdata
);
  import rr_pkg::*;

  // reference model of the trace, oldest entry first
  trace_entry_t trace_q[$];
  rr_mode_e     m_mode;
  logic         at_full;
  int           exp_count = 0;
  // bookkeeping
  int           errors = 0;
  int           errors_at_start = 0;
  int           tests_ok = 0;
  int           tests_bad = 0;

  ////////////////////////////////////////
  // compare and report
  ////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail at %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, errors - errors_at_start);
      tests_bad++;
    end
    errors_at_start = errors;
  endtask

  task automatic report();
    $display("tests ok: %0d, tests with errors: %0d, errors: %0d", tests_ok, tests_bad, errors);
  endtask

  ////////////////////////////////////////
  // per-channel transfer check
  ////////////////////////////////////////
  task automatic check_channel(
    input int                ch,
    input logic              host_valid,
    input logic              host_ready,
    input logic [ADDR_W-1:0] host_addr,
    input logic [DATA_W-1:0] host_data,
    input logic              core_valid,
    input logic              core_ready,
    input logic [ADDR_W-1:0] core_addr,
    input logic [DATA_W-1:0] core_data
  );
    trace_entry_t ent;
    logic         host_fire;
    logic         core_fire;
    host_fire = host_valid && host_ready;
    core_fire = core_valid && core_ready;
    if (m_mode == RR_MODE_REPLAY) begin
      // host is locked out, core must see the trace in order
      check_value($sformatf("o_host_c%0d_ready", ch), 32'd0, 32'(host_ready));
      if (core_fire) begin
        if (trace_q.size() == 0) begin
          $display("Error at %0d ns: core channel %0d got a request that was never recorded",
                   $time, ch);
          errors++;
        end else begin
          ent = trace_q.pop_front();
          exp_count--;
          check_value($sformatf("channel id of o_core_c%0d", ch), 32'(ent.chan), 32'(ch));
          check_value($sformatf("o_core_c%0d_addr", ch), 32'(ent.addr), 32'(core_addr));
          check_value($sformatf("o_core_c%0d_data", ch), 32'(ent.data), 32'(core_data));
        end
      end
    end else begin
      // full buffer in record mode stalls everything
      if (at_full) begin
        check_value($sformatf("o_host_c%0d_ready", ch), 32'd0, 32'(host_ready));
        check_value($sformatf("o_core_c%0d_valid", ch), 32'd0, 32'(core_valid));
      end
      // host and core transfers fall on the same edge
      check_value($sformatf("core transfer on c%0d", ch), 32'(host_fire), 32'(core_fire));
      if (host_fire && core_fire) begin
        check_value($sformatf("o_core_c%0d_addr", ch), 32'(host_addr), 32'(core_addr));
        check_value($sformatf("o_core_c%0d_data", ch), 32'(host_data), 32'(core_data));
        if (m_mode == RR_MODE_RECORD) begin
          ent.chan = CHAN_W'(ch);
          ent.addr = host_addr;
          ent.data = host_data;
          trace_q.push_back(ent);
          exp_count++;
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // monitor
  ////////////////////////////////////////
  // inputs settle 1 ns after the rising edge, the falling edge sees them stable
  always @(negedge clk) begin
    if (!rstn) begin
      m_mode    = RR_MODE_PASS;
      exp_count = 0;
      trace_q.delete();
    end else begin
      at_full = (m_mode == RR_MODE_RECORD) && (exp_count == TRACE_DEPTH);
      if (m_mode == RR_MODE_RECORD && i_core_c0_valid && i_core_c1_valid) begin
        $display("Error at %0d ns: both core channels granted in one cycle", $time);
        errors++;
      end
      check_channel(0, i_host_c0_valid, i_host_c0_ready, i_host_c0_addr, i_host_c0_data,
                    i_core_c0_valid, i_core_c0_ready, i_core_c0_addr, i_core_c0_data);
      check_channel(1, i_host_c1_valid, i_host_c1_ready, i_host_c1_addr, i_host_c1_data,
                    i_core_c1_valid, i_core_c1_ready, i_core_c1_addr, i_core_c1_data);
      // mode takes defined values only, on the coming edge
      if (i_cfg_we && i_cfg_addr == CSR_MODE && i_cfg_wdata <= 32'd2) begin
        m_mode = rr_mode_e'(i_cfg_wdata[1:0]);
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import rr_pkg::*;

  localparam int TRACE_DEPTH = 16;
  localparam int CLK_HALF    = 20;
  // cycle limit of every wait loop
  localparam int WAIT_LIMIT  = 2000;

  logic                  clk;
  logic                  rstn;
  logic                  host_c0_valid;
  logic                  host_c0_ready;
  logic [ADDR_W-1:0]     host_c0_addr;
  logic [DATA_W-1:0]     host_c0_data;
  logic                  core_c0_valid;
  logic                  core_c0_ready;
  logic [ADDR_W-1:0]     core_c0_addr;
  logic [DATA_W-1:0]     core_c0_data;
  logic                  host_c1_valid;
  logic                  host_c1_ready;
  logic [ADDR_W-1:0]     host_c1_addr;
  logic [DATA_W-1:0]     host_c1_data;
  logic                  core_c1_valid;
  logic                  core_c1_ready;
  logic [ADDR_W-1:0]     core_c1_addr;
  logic [DATA_W-1:0]     core_c1_data;
  logic                  cfg_we;
  logic                  cfg_re;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_wdata;
  logic [CFG_DATA_W-1:0] cfg_rdata;
  integer                seed;
  logic                  timed_out;

  rr_top #(
    .TRACE_DEPTH (TRACE_DEPTH)
  ) dut (
    .clk             (clk),
    .rstn            (rstn),
    .i_host_c0_valid (host_c0_valid),
    .i_host_c0_addr  (host_c0_addr),
    .i_host_c0_data  (host_c0_data),
    .o_host_c0_ready (host_c0_ready),
    .o_core_c0_valid (core_c0_valid),
    .o_core_c0_addr  (core_c0_addr),
    .o_core_c0_data  (core_c0_data),
    .i_core_c0_ready (core_c0_ready),
    .i_host_c1_valid (host_c1_valid),
    .i_host_c1_addr  (host_c1_addr),
    .i_host_c1_data  (host_c1_data),
    .o_host_c1_ready (host_c1_ready),
    .o_core_c1_valid (core_c1_valid),
    .o_core_c1_addr  (core_c1_addr),
    .o_core_c1_data  (core_c1_data),
    .i_core_c1_ready (core_c1_ready),
    .i_cfg_we        (cfg_we),
    .i_cfg_re        (cfg_re),
    .i_cfg_addr      (cfg_addr),
    .i_cfg_wdata     (cfg_wdata),
    .o_cfg_rdata     (cfg_rdata)
  );

  rr_checker #(
    .TRACE_DEPTH (TRACE_DEPTH)
  ) chk (
    .clk             (clk),
    .rstn            (rstn),
    .i_host_c0_valid (host_c0_valid),
    .i_host_c0_ready (host_c0_ready),
    .i_host_c0_addr  (host_c0_addr),
    .i_host_c0_data  (host_c0_data),
    .i_core_c0_valid (core_c0_valid),
    .i_core_c0_ready (core_c0_ready),
    .i_core_c0_addr  (core_c0_addr),
    .i_core_c0_data  (core_c0_data),
    .i_host_c1_valid (host_c1_valid),
    .i_host_c1_ready (host_c1_ready),
    .i_host_c1_addr  (host_c1_addr),
    .i_host_c1_data  (host_c1_data),
    .i_core_c1_valid (core_c1_valid),
    .i_core_c1_ready (core_c1_ready),
    .i_core_c1_addr  (core_c1_addr),
    .i_core_c1_data  (core_c1_data),
    .i_cfg_we        (cfg_we),
    .i_cfg_addr      (cfg_addr),
    .i_cfg_wdata     (cfg_wdata)
  );

  // 40 ns clock
  always #(CLK_HALF) clk = ~clk;

  ////////////////////////////////////////
  // register port access
  ////////////////////////////////////////
  // all tasks start 1 ns after a rising edge and end there
  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [CFG_DATA_W-1:0] wdata);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = wdata;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic cfg_read(input logic [CFG_ADDR_W-1:0] addr, output logic [CFG_DATA_W-1:0] rdata);
    cfg_re   = 1'b1;
    cfg_addr = addr;
    @(posedge clk);
    #1;
    cfg_re = 1'b0;
    // registered read data is valid from the edge that took the read
    rdata = cfg_rdata;
  endtask

  task automatic read_expect(input string name, input logic [CFG_ADDR_W-1:0] addr,
                             input logic [CFG_DATA_W-1:0] exp);
    logic [CFG_DATA_W-1:0] rdata;
    cfg_read(addr, rdata);
    chk.check_value(name, exp, rdata);
  endtask

  ////////////////////////////////////////
  // random host traffic
  ////////////////////////////////////////
  task automatic next_request(input logic allow, output logic valid,
                              output logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    valid = allow && 1'($random(seed));
    addr  = ADDR_W'($random(seed));
    data  = DATA_W'($random(seed));
  endtask

  // runs until target host transfers, then optionally until no request is pending
  task automatic run_traffic(input int target, input logic drain);
    int   fires;
    int   cycles;
    logic fire0;
    logic fire1;
    logic busy;
    fires  = 0;
    cycles = 0;
    busy   = 1'b1;
    while (busy && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      fire0 = host_c0_valid && host_c0_ready;
      fire1 = host_c1_valid && host_c1_ready;
      if (fire0) fires++;
      if (fire1) fires++;
      @(posedge clk);
      #1;
      // a request holds until it transfers
      if (fire0 || !host_c0_valid) begin
        next_request(fires < target, host_c0_valid, host_c0_addr, host_c0_data);
      end
      if (fire1 || !host_c1_valid) begin
        next_request(fires < target, host_c1_valid, host_c1_addr, host_c1_data);
      end
      core_c0_ready = 1'($random(seed));
      core_c1_ready = 1'($random(seed));
      cycles++;
      busy = (fires < target) || (drain && (host_c0_valid || host_c1_valid));
    end
    if (busy) begin
      $display("Timeout: only %0d of %0d host transfers within %0d cycles",
               fires, target, WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////
  task automatic test_pass_mode();
    read_expect("CSR_MODE", CSR_MODE, 32'(RR_MODE_PASS));
    read_expect("CSR_STATUS", CSR_STATUS, 32'd0);
    run_traffic(20, 1'b1);
    if (timed_out) return;
    read_expect("CSR_COUNT", CSR_COUNT, 32'd0);
    chk.end_test("1 pass mode");
  endtask

  task automatic test_record();
    cfg_write(CSR_MODE, 32'(RR_MODE_RECORD));
    run_traffic(10, 1'b1);
    if (timed_out) return;
    read_expect("CSR_COUNT", CSR_COUNT, 32'(chk.exp_count));
    chk.end_test("2 record mode");
  endtask

  task automatic test_full();
    run_traffic(TRACE_DEPTH - chk.exp_count, 1'b0);
    if (timed_out) return;
    // both hosts offer and the core is ready, the full buffer holds them off
    host_c0_valid = 1'b1;
    host_c1_valid = 1'b1;
    core_c0_ready = 1'b1;
    core_c1_ready = 1'b1;
    repeat (20) @(posedge clk);
    #1;
    read_expect("CSR_STATUS", CSR_STATUS, 32'(1 << STAT_FULL));
    read_expect("CSR_COUNT", CSR_COUNT, 32'(TRACE_DEPTH));
    chk.end_test("3 buffer full");
  endtask

  task automatic test_replay();
    logic [CFG_DATA_W-1:0] status;
    int                    cycles;
    cfg_write(CSR_MODE, 32'(RR_MODE_REPLAY));
    status = '0;
    cycles = 0;
    // poll for done, core back-pressure stays random
    while (!status[STAT_REPLAY_DONE] && cycles < WAIT_LIMIT) begin
      core_c0_ready = 1'($random(seed));
      core_c1_ready = 1'($random(seed));
      cfg_read(CSR_STATUS, status);
      cycles++;
    end
    if (!status[STAT_REPLAY_DONE]) begin
      $display("Timeout: replay did not report done within %0d cycles", WAIT_LIMIT);
      timed_out = 1'b1;
      return;
    end
    chk.check_value("trace entries not replayed", 32'd0, 32'(chk.exp_count));
    read_expect("CSR_STATUS", CSR_STATUS, 32'(1 << STAT_REPLAY_DONE));
    read_expect("CSR_COUNT", CSR_COUNT, 32'd0);
    host_c0_valid = 1'b0;
    host_c1_valid = 1'b0;
    chk.end_test("4 replay");
  endtask

  task automatic test_registers();
    cfg_write(CSR_MODE, 32'(RR_MODE_PASS));
    read_expect("CSR_STATUS", CSR_STATUS, 32'd0);
    cfg_write(CSR_MODE, 32'(RR_MODE_RECORD));
    // value 3 is no mode
    cfg_write(CSR_MODE, 32'd3);
    read_expect("CSR_MODE", CSR_MODE, 32'(RR_MODE_RECORD));
    read_expect("unknown register", 4'hf, 32'd0);
    cfg_write(CSR_MODE, 32'(RR_MODE_PASS));
    read_expect("CSR_MODE", CSR_MODE, 32'(RR_MODE_PASS));
    chk.end_test("5 register port");
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    clk           = 1'b0;
    rstn          = 1'b0;
    seed          = 43502;
    timed_out     = 1'b0;
    host_c0_valid = 1'b0;
    host_c0_addr  = '0;
    host_c0_data  = '0;
    core_c0_ready = 1'b0;
    host_c1_valid = 1'b0;
    host_c1_addr  = '0;
    host_c1_data  = '0;
    core_c1_ready = 1'b0;
    cfg_we        = 1'b0;
    cfg_re        = 1'b0;
    cfg_addr      = '0;
    cfg_wdata     = '0;
    repeat (10) @(posedge clk);
    #1;
    rstn = 1'b1;
    test_pass_mode();
    if (!timed_out) test_record();
    if (!timed_out) test_full();
    if (!timed_out) test_replay();
    if (!timed_out) test_registers();
    chk.report();
    if (!timed_out && chk.errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
